//--- src.f
+incdir+include
+incdir+tests
hw/csr_pkg.sv
hw/csr_timer.sv
hw/csr_regfile.sv
hw/csr_issue.sv
hw/csr_top.sv
tests/csr_sva.sv
tests/csr_tb.sv

//--- Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/csr_pkg.sv
      - hw/csr_timer.sv
      - hw/csr_regfile.sv
      - hw/csr_issue.sv
      - hw/csr_top.sv
  - target: test
    include_dirs:
      - include
      - tests
    files:
      - tests/csr_sva.sv
      - tests/csr_tb.sv

//--- tests/csr_tb_tasks.svh
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

typedef struct packed {
    csr_op_e   op;
    csr_num_t  num;
    word_t     wdata;
    word_t     wmask;
    word_t     pc;
    logic      excp;
    ecode_t    ecode;
    esubcode_t esub;
    word_t     badv;
    word_t     exp_rdata;
    logic      chk_rdata;
    logic      exp_flush;
    word_t     exp_redirect;
    logic      exp_excp;
    logic      exp_ertn;
    csr_num_t  chk_num;
    word_t     chk_val;
} entry_t;

function automatic csr_req_t idle_req();
    csr_req_t r;
    r    = '0;
    r.pc = IDLE_PC;
    return r;
endfunction

task automatic check_word(input string sig, input word_t got, input word_t exp);
    assert (got === exp)
    else
    begin
        $display("Mismatch %s: got %h expected %h", sig, got, exp);
        err_count++;
    end
endtask

// one read through the pipe and back to idle at a falling edge
task automatic read_csr(input csr_num_t num, output word_t data);
    csr_req_t r;
    r       = idle_req();
    r.valid = 1'b1;
    r.op    = OP_CSRRD;
    r.num   = num;
    req     = r;
    @(posedge clk);
    @(negedge clk);
    data = resp.rdata;
    req  = idle_req();
endtask

task automatic apply_entry(input int idx, input string name, input entry_t e);
    csr_req_t  r;
    csr_resp_t got;
    word_t     rb;
    int        errs_before;
    errs_before  = err_count;
    r            = idle_req();
    r.valid      = 1'b1;
    r.op         = e.op;
    r.num        = e.num;
    r.wdata      = e.wdata;
    r.wmask      = e.wmask;
    r.pc         = e.pc;
    r.excp_valid = e.excp;
    r.ecode      = e.ecode;
    r.esubcode   = e.esub;
    r.badv       = e.badv;
    req          = r;
    @(posedge clk);
    @(negedge clk);
    got = resp;
    req = idle_req();
    if (e.chk_rdata)
        check_word("resp.rdata", got.rdata, e.exp_rdata);
    check_word("resp.flush", word_t'(got.flush), word_t'(e.exp_flush));
    if (e.exp_flush)
        check_word("resp.redirect_pc", got.redirect_pc, e.exp_redirect);
    // commit pulses show in the idle cycle
    @(posedge clk);
    @(negedge clk);
    check_word("excp_flush", word_t'(excp_flush), word_t'(e.exp_excp));
    check_word("ertn_flush", word_t'(ertn_flush), word_t'(e.exp_ertn));
    read_csr(e.chk_num, rb);
    check_word($sformatf("csr %h readback", e.chk_num), rb, e.chk_val);
    test_count++;
    $display("test %0d %-16s %s", idx, name, (err_count == errs_before) ? "ok" : "errors");
endtask

task automatic wait_excp_flush(input int limit, output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < limit)
    begin
        @(negedge clk);
        seen = excp_flush;
        n++;
    end
    assert (seen)
    else
    begin
        $display("timer interrupt did not raise excp_flush within %0d cycles", limit);
        err_count++;
    end
endtask

`endif

//--- tests/csr_tb.sv
`include "csr_params.svh"

module csr_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam word_t IDLE_PC    = 32'h1c00_8000;
    localparam word_t TIMER_INIT = 32'h20;
    localparam int    TIMER_WAIT = 2 * TIMER_INIT + 16;

    logic       clk;
    logic       rstn;
    csr_req_t   req;
    logic       stall;
    logic       flush;
    int_lines_t int_lines;
    csr_resp_t  resp;
    logic       excp_flush;
    logic       ertn_flush;
    logic [8:0] crmd;

    int    err_count;
    int    test_count;
    int    cycles;
    int    cycle_limit;
    int    seed;
    word_t shadow [0:16383];

    `include "csr_tb_tasks.svh"

    entry_t tbl [$];
    string  names [$];

    csr_top csr_top_i (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .stall      (stall),
        .flush      (flush),
        .int_lines  (int_lines),
        .resp       (resp),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic word_t rnd();
        return word_t'($random(seed));
    endfunction

    // architectural value kept after a write
    function automatic word_t stored_value(csr_num_t num, word_t old_v, word_t new_v);
        word_t v;
        v = old_v;
        case (num)
            `CSR_CRMD:
            begin
                v = {23'b0, new_v[8:5], old_v[4:3], new_v[2:0]};
                if (new_v[4] != new_v[3])
                    v[4:3] = new_v[4:3];
            end
            `CSR_PRMD:   v = new_v & 32'h7;
            `CSR_EUEN:   v = new_v & 32'h1;
            `CSR_ECFG:   v = new_v & 32'h1bff;
            `CSR_ESTAT:  v = {old_v[31:2], new_v[1:0]};
            `CSR_EENTRY: v = {new_v[31:6], 6'b0};
            `CSR_ERA, `CSR_BADV, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
            `CSR_TID, `CSR_TCFG:
                v = new_v;
            default:     v = old_v;
        endcase
        return v;
    endfunction

    function automatic void take_trap(word_t pc, ecode_t ecode, esubcode_t esub, word_t badv);
        shadow[`CSR_PRMD]       = {29'b0, shadow[`CSR_CRMD][2:0]};
        shadow[`CSR_CRMD][2:0]  = 3'b000;
        shadow[`CSR_ERA]        = pc;
        shadow[`CSR_ESTAT]      = {1'b0, esub, ecode, 14'b0, shadow[`CSR_ESTAT][1:0]};
        case (ecode)
            `ECODE_ALE, `ECODE_PIL, `ECODE_PIS, `ECODE_PIF, `ECODE_PME, `ECODE_PPI:
                shadow[`CSR_BADV] = badv;
            `ECODE_ADE:
                if (esub == `ESUBCODE_ADEF)
                    shadow[`CSR_BADV] = pc;
            default: ;
        endcase
    endfunction

    function automatic void add_entry(string name, csr_op_e op, csr_num_t num, word_t wdata,
                                      word_t wmask, logic excp, ecode_t ecode,
                                      esubcode_t esub, word_t badv, csr_num_t chk_num);
        entry_t e;
        word_t  old_v;
        e           = '0;
        e.op        = op;
        e.num       = num;
        e.wdata     = wdata;
        e.wmask     = wmask;
        e.pc        = 32'h1c00_0000 + 32'(tbl.size()) * 4;
        e.excp      = excp;
        e.ecode     = ecode;
        e.esub      = esub;
        e.badv      = badv;
        old_v       = shadow[num];
        e.exp_rdata = old_v;
        e.chk_rdata = !excp && (op != OP_ERTN);
        if (excp)
        begin
            e.exp_flush    = 1'b1;
            e.exp_redirect = shadow[`CSR_EENTRY];
            e.exp_excp     = 1'b1;
            take_trap(e.pc, ecode, esub, badv);
        end
        else if (op == OP_CSRWR || op == OP_CSRXCHG)
        begin
            e.exp_flush    = 1'b1;
            e.exp_redirect = e.pc + 32'd4;
            if (op == OP_CSRXCHG)
                shadow[num] = stored_value(num, old_v, (wdata & wmask) | (old_v & ~wmask));
            else
                shadow[num] = stored_value(num, old_v, wdata);
        end
        else if (op == OP_ERTN)
        begin
            e.exp_flush            = 1'b1;
            e.exp_redirect         = shadow[`CSR_ERA];
            e.exp_ertn             = 1'b1;
            shadow[`CSR_CRMD][2:0] = shadow[`CSR_PRMD][2:0];
        end
        e.chk_num = chk_num;
        e.chk_val = shadow[chk_num];
        tbl.push_back(e);
        names.push_back(name);
    endfunction

    function automatic void add_access(string name, csr_op_e op, csr_num_t num, word_t wdata,
                                       word_t wmask, csr_num_t chk_num);
        add_entry(name, op, num, wdata, wmask, 1'b0, '0, '0, '0, chk_num);
    endfunction

    function automatic void add_trap(string name, ecode_t ecode, esubcode_t esub, word_t badv,
                                     csr_num_t chk_num);
        add_entry(name, OP_NONE, '0, '0, '0, 1'b1, ecode, esub, badv, chk_num);
    endfunction

    function automatic void build_table();
        csr_num_t wr_list [0:5];
        wr_list = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_ERA};
        for (int i = 0; i < 16384; i++)
            shadow[i] = '0;
        shadow[`CSR_CRMD] = 32'(`CRMD_RESET);
        add_access("reset crmd", OP_CSRRD, `CSR_CRMD, '0, '0, `CSR_CRMD);
        add_access("reset tcfg", OP_CSRRD, `CSR_TCFG, '0, '0, `CSR_TCFG);
        add_access("reset save0", OP_CSRRD, `CSR_SAVE0, '0, '0, `CSR_SAVE0);
        add_access("reset era", OP_CSRRD, `CSR_ERA, '0, '0, `CSR_ERA);
        for (int i = 0; i < 6; i++)
            add_access("write", OP_CSRWR, wr_list[i], rnd(), '0, wr_list[i]);
        add_access("rewrite save0", OP_CSRWR, `CSR_SAVE0, rnd(), '0, `CSR_SAVE0);
        add_access("write eentry", OP_CSRWR, `CSR_EENTRY, rnd(), '0, `CSR_EENTRY);
        add_access("xchg save1", OP_CSRXCHG, `CSR_SAVE1, rnd(), rnd(), `CSR_SAVE1);
        add_access("xchg tid", OP_CSRXCHG, `CSR_TID, rnd(), rnd(), `CSR_TID);
        add_access("unkept read", OP_CSRRD, 14'h123, '0, '0, 14'h123);
        add_access("unkept write", OP_CSRWR, 14'h0ff, rnd(), '0, 14'h0ff);
        // plv 3 so the trap has low bits to save
        add_access("crmd plv3", OP_CSRWR, `CSR_CRMD, 32'h0b, '0, `CSR_CRMD);
        add_trap("trap ale", `ECODE_ALE, '0, rnd(), `CSR_BADV);
        add_access("read era", OP_CSRRD, `CSR_ERA, '0, '0, `CSR_ESTAT);
        add_access("read prmd", OP_CSRRD, `CSR_PRMD, '0, '0, `CSR_CRMD);
        add_access("ertn", OP_ERTN, '0, '0, '0, `CSR_CRMD);
        add_trap("trap sys", `ECODE_SYS, 9'h0a5, rnd(), `CSR_BADV);
        add_access("read estat", OP_CSRRD, `CSR_ESTAT, '0, '0, `CSR_ERA);
        add_access("ertn", OP_ERTN, '0, '0, '0, `CSR_PRMD);
        add_trap("trap adef", `ECODE_ADE, `ESUBCODE_ADEF, rnd(), `CSR_BADV);
        add_access("ertn", OP_ERTN, '0, '0, '0, `CSR_CRMD);
        add_access("crmd da=pg", OP_CSRWR, `CSR_CRMD, 32'h1b, '0, `CSR_CRMD);
        add_access("crmd pg", OP_CSRWR, `CSR_CRMD, 32'h13, '0, `CSR_CRMD);
        add_access("crmd da", OP_CSRWR, `CSR_CRMD, 32'h08, '0, `CSR_CRMD);
        // timer interrupt setup with the enable last
        add_access("ecfg timer", OP_CSRWR, `CSR_ECFG, 32'h800, '0, `CSR_ECFG);
        add_access("crmd ie", OP_CSRWR, `CSR_CRMD, 32'h0c, '0, `CSR_CRMD);
        add_access("tcfg enable", OP_CSRWR, `CSR_TCFG, TIMER_INIT | 32'h1, '0, `CSR_TCFG);
    endfunction

    initial
    begin
        word_t rb;
        logic  seen;
        int    errs_before;
        clk         = 1'b0;
        rstn        = 1'b0;
        req         = idle_req();
        stall       = 1'b0;
        flush       = 1'b0;
        int_lines   = '0;
        err_count   = 0;
        test_count  = 0;
        cycles      = 0;
        seed        = 32'h66e05884;
        build_table();
        cycle_limit = 16 + (tbl.size() + 1) * 8 + TIMER_WAIT + 64;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_word("crmd", word_t'(crmd), word_t'(`CRMD_RESET));

        foreach (tbl[i])
            apply_entry(i, names[i], tbl[i]);

        errs_before = err_count;
        wait_excp_flush(TIMER_WAIT, seen);
        take_trap(IDLE_PC, `ECODE_INT, '0, '0);
        read_csr(`CSR_ESTAT, rb);
        check_word("estat", rb, shadow[`CSR_ESTAT] | (32'h1 << `ESTAT_TI));
        read_csr(`CSR_ERA, rb);
        check_word("era", rb, shadow[`CSR_ERA]);
        read_csr(`CSR_CRMD, rb);
        check_word("crmd", rb, shadow[`CSR_CRMD]);
        test_count++;
        $display("test %0d %-16s %s", tbl.size(), "timer irq",
                 (err_count == errs_before) ? "ok" : "errors");

        add_access("ticlr", OP_CSRWR, `CSR_TICLR, 32'h1, '0, `CSR_ESTAT);
        apply_entry(tbl.size() - 1, names[names.size() - 1], tbl[tbl.size() - 1]);

        assert (csr_top_i.csr_sva_i.fail_count == 0)
        else
        begin
            $display("bound assertions failed %0d times", csr_top_i.csr_sva_i.fail_count);
            err_count++;
        end

        $display("tests run: %0d, check errors: %0d", test_count, err_count);
        if (err_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- tests/csr_sva.sv
module csr_sva (
    input logic               clk,
    input logic               rstn,
    input csr_pkg::csr_resp_t resp,
    input logic               excp_flush,
    input logic               ertn_flush
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // trap and return never commit in the same cycle
    assert property (@(posedge clk) disable iff (!rstn) !(excp_flush && ertn_flush))
    else
    begin
        fail_count++;
        $error("excp_flush and ertn_flush high together");
    end

    // a commit pulse always comes one cycle after the flushing response
    assert property (@(posedge clk) disable iff (!rstn)
                     (excp_flush || ertn_flush) |-> $past(resp.flush))
    else
    begin
        fail_count++;
        $error("flush pulse without a preceding resp.flush");
    end

    assert property (@(posedge clk) $rose(rstn) |=> (!excp_flush && !ertn_flush))
    else
    begin
        fail_count++;
        $error("flush outputs high right after reset");
    end

endmodule

bind csr_top csr_sva csr_sva_i (
    .clk        (clk),
    .rstn       (rstn),
    .resp       (resp),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush)
);

//--- hw/csr_top.sv
module csr_top (
    input  logic                clk,
    input  logic                rstn,
    input  csr_pkg::csr_req_t   req,
    input  logic                stall,
    input  logic                flush,
    input  csr_pkg::int_lines_t int_lines,
    output csr_pkg::csr_resp_t  resp,
    output logic                excp_flush,
    output logic                ertn_flush,
    output logic [8:0]          crmd
);
    import csr_pkg::*;

    csr_num_t     rd_num;
    word_t        rd_data;
    csr_vectors_t vectors;
    logic         int_req;
    csr_commit_t  commit;
    timer_state_t timer;

    csr_issue csr_issue_i (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .stall   (stall),
        .flush   (flush),
        .rd_num  (rd_num),
        .rd_data (rd_data),
        .vectors (vectors),
        .int_req (int_req),
        .commit  (commit),
        .resp    (resp)
    );

    csr_regfile csr_regfile_i (
        .clk        (clk),
        .rstn       (rstn),
        .commit     (commit),
        .rd_num     (rd_num),
        .rd_data    (rd_data),
        .timer      (timer),
        .int_lines  (int_lines),
        .vectors    (vectors),
        .int_req    (int_req),
        .crmd       (crmd),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    csr_timer csr_timer_i (
        .clk    (clk),
        .rstn   (rstn),
        .commit (commit),
        .timer  (timer)
    );

endmodule

//--- hw/csr_issue.sv
`include "csr_params.svh"

module csr_issue (
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_pkg::csr_req_t     req,
    input  logic                  stall,
    input  logic                  flush,
    output csr_pkg::csr_num_t     rd_num,
    input  csr_pkg::word_t        rd_data,
    input  csr_pkg::csr_vectors_t vectors,
    input  logic                  int_req,
    output csr_pkg::csr_commit_t  commit,
    output csr_pkg::csr_resp_t    resp
);
    import csr_pkg::*;

    logic        accept;
    logic        int_take;
    word_t       merged;
    csr_commit_t nxt;
    csr_resp_t   nxt_resp;

    assign rd_num = req.num;
    assign accept = req.valid && !stall && !flush;
    // no re-entry until the pending trap has cleared ie
    assign int_take = int_req && (commit.kind != COMMIT_TRAP);

    assign merged = (req.op == OP_CSRXCHG)
                  ? ((req.wdata & req.wmask) | (rd_data & ~req.wmask))
                  : req.wdata;

    always_comb
    begin
        nxt          = '0;
        nxt_resp     = '0;
        nxt.num      = req.num;
        nxt.pc       = req.pc;
        nxt.wdata    = merged;
        if (int_take)
        begin
            nxt.kind  = COMMIT_TRAP;
            nxt.ecode = `ECODE_INT;
        end
        else if (accept && req.excp_valid)
        begin
            nxt.kind     = COMMIT_TRAP;
            nxt.ecode    = req.ecode;
            nxt.esubcode = req.esubcode;
            nxt.badv     = req.badv;
            case (req.ecode)
                `ECODE_ALE, `ECODE_PIL, `ECODE_PIS, `ECODE_PIF, `ECODE_PME, `ECODE_PPI:
                    nxt.badv_we = 1'b1;
                `ECODE_ADE:
                begin
                    // fetch address error reports the pc
                    if (req.esubcode == `ESUBCODE_ADEF)
                    begin
                        nxt.badv_we = 1'b1;
                        nxt.badv    = req.pc;
                    end
                end
                default: ;
            endcase
        end
        else if (accept)
        begin
            nxt_resp.rdata = rd_data;
            case (req.op)
                OP_CSRWR, OP_CSRXCHG:
                begin
                    nxt.kind             = COMMIT_WRITE;
                    nxt_resp.flush       = 1'b1;
                    nxt_resp.redirect_pc = req.pc + 32'd4;
                end
                OP_ERTN:
                begin
                    nxt.kind             = COMMIT_ERTN;
                    nxt_resp.flush       = 1'b1;
                    nxt_resp.redirect_pc = vectors.era;
                end
                default: ;
            endcase
        end

        if (nxt.kind == COMMIT_TRAP)
        begin
            nxt_resp.flush       = 1'b1;
            nxt_resp.redirect_pc = vectors.eentry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn || (flush && !int_take))
        begin
            commit <= '0;
            resp   <= '0;
        end
        else if (!stall || int_take)
        begin
            commit <= nxt;
            resp   <= nxt_resp;
        end
        else
            // response held under stall so the commit fires once
            commit.kind <= COMMIT_NONE;
    end

endmodule

//--- hw/csr_regfile.sv
`include "csr_params.svh"

module csr_regfile (
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_pkg::csr_commit_t  commit,
    input  csr_pkg::csr_num_t     rd_num,
    output csr_pkg::word_t        rd_data,
    input  csr_pkg::timer_state_t timer,
    input  csr_pkg::int_lines_t   int_lines,
    output csr_pkg::csr_vectors_t vectors,
    output logic                  int_req,
    output logic [8:0]            crmd,
    output logic                  excp_flush,
    output logic                  ertn_flush
);
    import csr_pkg::*;

    logic [2:0]                 prmd;
    logic                       euen;
    // bit 10 stays zero
    logic [12:0]                ecfg_lie;
    logic [1:0]                 estat_is;
    ecode_t                     estat_ecode;
    esubcode_t                  estat_esub;
    word_t                      era;
    word_t                      badv;
    logic [31:`EENTRY_ALIGN]    eentry;
    word_t                      save [0:3];
    word_t                      tid;
    logic [12:0]                pending;
    word_t                      wd;

    assign wd      = commit.wdata;
    assign pending = {int_lines[8], timer.ti_pending, 1'b0, int_lines[7:0], estat_is};
    assign int_req = crmd[`CRMD_IE] && |(pending & ecfg_lie);

    assign vectors.era    = era;
    assign vectors.eentry = {eentry, {`EENTRY_ALIGN{1'b0}}};

    always_comb
    begin
        case (rd_num)
            `CSR_CRMD:   rd_data = {23'b0, crmd};
            `CSR_PRMD:   rd_data = {29'b0, prmd};
            `CSR_EUEN:   rd_data = {31'b0, euen};
            `CSR_ECFG:   rd_data = {19'b0, ecfg_lie};
            `CSR_ESTAT:  rd_data = {1'b0, estat_esub, estat_ecode, 3'b0, pending};
            `CSR_ERA:    rd_data = era;
            `CSR_BADV:   rd_data = badv;
            `CSR_EENTRY: rd_data = vectors.eentry;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                rd_data = save[rd_num[1:0]];
            `CSR_TID:    rd_data = tid;
            `CSR_TCFG:   rd_data = word_t'(timer.tcfg);
            `CSR_TVAL:   rd_data = word_t'(timer.tval);
            // ticlr and unkept numbers
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= `CRMD_RESET;
            prmd        <= '0;
            euen        <= 1'b0;
            ecfg_lie    <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era         <= '0;
            badv        <= '0;
            eentry      <= '0;
            save        <= '{default: '0};
            tid         <= '0;
            excp_flush  <= 1'b0;
            ertn_flush  <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            case (commit.kind)
                COMMIT_TRAP:
                begin
                    prmd        <= crmd[2:0];
                    crmd[2:0]   <= 3'b000;
                    era         <= commit.pc;
                    estat_ecode <= commit.ecode;
                    estat_esub  <= commit.esubcode;
                    if (commit.badv_we)
                        badv <= commit.badv;
                    excp_flush  <= 1'b1;
                end
                COMMIT_ERTN:
                begin
                    crmd[2:0]  <= prmd;
                    ertn_flush <= 1'b1;
                end
                COMMIT_WRITE:
                begin
                    case (commit.num)
                        `CSR_CRMD:
                        begin
                            crmd[2:0] <= wd[2:0];
                            crmd[8:5] <= wd[8:5];
                            // da/pg only move to a legal pair
                            if (wd[4] ^ wd[3])
                                crmd[4:3] <= wd[4:3];
                        end
                        `CSR_PRMD:   prmd     <= wd[2:0];
                        `CSR_EUEN:   euen     <= wd[0];
                        `CSR_ECFG:   ecfg_lie <= wd[12:0] & 13'h1bff;
                        `CSR_ESTAT:  estat_is <= wd[1:0];
                        `CSR_ERA:    era      <= wd;
                        `CSR_BADV:   badv     <= wd;
                        `CSR_EENTRY: eentry   <= wd[31:`EENTRY_ALIGN];
                        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                            save[commit.num[1:0]] <= wd;
                        `CSR_TID:    tid      <= wd;
                        // timer registers live in csr_timer
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hw/csr_timer.sv
`include "csr_params.svh"

module csr_timer (
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_pkg::csr_commit_t  commit,
    output csr_pkg::timer_state_t timer
);
    import csr_pkg::*;

    timer_t tcfg;
    timer_t tval;
    timer_t init_val;
    logic   ti_pending;
    logic   en_q;
    logic   en;
    logic   tcfg_we;
    logic   ticlr_we;

    assign en       = tcfg[`TCFG_EN];
    assign init_val = {tcfg[`CSR_TIMER_W-1:2], 2'b00};
    assign tcfg_we  = (commit.kind == COMMIT_WRITE) && (commit.num == `CSR_TCFG);
    assign ticlr_we = (commit.kind == COMMIT_WRITE) && (commit.num == `CSR_TICLR)
                      && commit.wdata[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg       <= '0;
            tval       <= '0;
            en_q       <= 1'b0;
            ti_pending <= 1'b0;
        end
        else
        begin
            en_q <= en;
            if (tcfg_we)
                tcfg <= commit.wdata[`CSR_TIMER_W-1:0];

            // pending on the step that reaches zero
            if (ticlr_we)
                ti_pending <= 1'b0;
            else if (en && en_q && tval == timer_t'(1))
                ti_pending <= 1'b1;

            if ((en && !en_q) || (en && tcfg[`TCFG_PERIODIC] && tval == '0))
                tval <= init_val;
            else if (!en && en_q)
                tval <= '0;
            else if (en && tval != '0)
                tval <= tval - timer_t'(1);
        end
    end

    assign timer.tcfg       = tcfg;
    assign timer.tval       = tval;
    assign timer.ti_pending = ti_pending;

endmodule

//--- hw/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    typedef logic [31:0]              word_t;
    typedef logic [13:0]              csr_num_t;
    typedef logic [5:0]               ecode_t;
    typedef logic [8:0]               esubcode_t;
    // ipi on bit 8 above the hardware lines
    typedef logic [8:0]               int_lines_t;
    typedef logic [`CSR_TIMER_W-1:0]  timer_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN
    } csr_op_e;

    typedef enum logic [1:0] {
        COMMIT_NONE,
        COMMIT_WRITE,
        COMMIT_TRAP,
        COMMIT_ERTN
    } commit_kind_e;

    typedef struct packed {
        logic       valid;
        csr_op_e    op;
        csr_num_t   num;
        word_t      wdata;
        word_t      wmask;
        word_t      pc;
        logic       excp_valid;
        ecode_t     ecode;
        esubcode_t  esubcode;
        word_t      badv;
    } csr_req_t;

    typedef struct packed {
        commit_kind_e kind;
        csr_num_t     num;
        word_t        wdata;
        word_t        pc;
        ecode_t       ecode;
        esubcode_t    esubcode;
        word_t        badv;
        logic         badv_we;
    } csr_commit_t;

    typedef struct packed {
        word_t rdata;
        logic  flush;
        word_t redirect_pc;
    } csr_resp_t;

    typedef struct packed {
        word_t era;
        word_t eentry;
    } csr_vectors_t;

    typedef struct packed {
        timer_t tcfg;
        timer_t tval;
        logic   ti_pending;
    } timer_state_t;

endpackage

//--- include/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// csr numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_EUEN        14'h002
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TID         14'h040
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// field positions
`define CRMD_IE         2
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define ESTAT_TI        11

// exception codes
`define ECODE_INT       6'h00
`define ECODE_PIL       6'h01
`define ECODE_PIS       6'h02
`define ECODE_PIF       6'h03
`define ECODE_PME       6'h04
`define ECODE_PPI       6'h07
`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ECODE_SYS       6'h0b
`define ECODE_BRK       6'h0c
`define ECODE_INE       6'h0d
`define ESUBCODE_ADEF   9'h000

`define CRMD_RESET      9'h008
`define CSR_TIMER_W     32
`define EENTRY_ALIGN    6

`endif
